/* bus_decode.sv */
`timescale 1ns/1ns
`include "ring_noc_params.svh"

// splits the host bus into one slave bus per node
// adr[9:8] picks the node, the base address is left to the node
module bus_decode (
  input  logic                    cyc,
  input  logic                    stb,
  input  logic                    we,
  input  ring_noc_pkg::bus_word_t adr,
  input  ring_noc_pkg::bus_word_t dat_w,
  output ring_noc_pkg::bus_word_t dat_r,
  output logic                    ack,
  noc_bus_if.host                 nodes [`RING_NODES]
);

  localparam int SEL_WID = $clog2(`RING_NODES);

  logic [SEL_WID-1:0]      sel;
  logic [`RING_NODES-1:0]  node_ack;
  ring_noc_pkg::bus_word_t node_dat [`RING_NODES];

  assign sel = adr[9:8];

  // ========================================================================
  // request fan out
  // ========================================================================

  for (genvar g = 0; g < `RING_NODES; g++) begin : g_port
    // only the addressed node sees a select
    assign nodes[g].cyc   = cyc && (sel == SEL_WID'(g));
    assign nodes[g].stb   = stb && (sel == SEL_WID'(g));

    // shared by all
    assign nodes[g].we    = we;
    assign nodes[g].adr   = adr;
    assign nodes[g].dat_w = dat_w;

    // gather responses
    assign node_ack[g]    = nodes[g].ack;
    assign node_dat[g]    = nodes[g].dat_r;
  end

  // ========================================================================
  // response mux
  // ========================================================================

  // unselected nodes keep ack low and dat_r at zero anyway
  assign ack   = node_ack[sel];
  assign dat_r = node_dat[sel];

endmodule

/* noc_bus_if.sv */
`timescale 1ns/1ns

// one slave bus between the address decoder and a single node
interface noc_bus_if;

  // select and transfer direction
  logic cyc;
  logic stb;
  logic we;

  // full host address, the node checks the base itself
  ring_noc_pkg::bus_word_t adr;
  ring_noc_pkg::bus_word_t dat_w;

  // zero unless ack is high
  ring_noc_pkg::bus_word_t dat_r;
  logic ack;

  // decoder side drives the request
  modport host (
    output cyc, stb, we, adr, dat_w,
    input  dat_r, ack
  );

  // node side answers
  modport node (
    input  cyc, stb, we, adr, dat_w,
    output dat_r, ack
  );

endinterface

/* ring_noc.f */
+incdir+.
ring_noc_pkg.sv
noc_bus_if.sv
rx_queue.sv
ring_node.sv
bus_decode.sv
ring_noc_top.sv
ring_noc_tb.sv

/* ring_noc_params.svh */
`ifndef RING_NOC_PARAMS_SVH
`define RING_NOC_PARAMS_SVH

// ==========================================================================
// packet layout
// ==========================================================================

// full slot width carried around the ring
`define RING_PACKET_WID 96

// receiver number, zero marks an empty slot
`define RING_RID_HI 95
`define RING_RID_LO 92

// transmitter number, stamped by the sending node
`define RING_TID_HI 91
`define RING_TID_LO 88

// set when the packet is an acknowledge heading back to its sender
`define RING_ACK_BIT 87

// receiver number that every node accepts
`define RING_GBL 15

// ==========================================================================
// sizing and address map
// ==========================================================================

`define RING_NODES 4
`define RXQ_DEPTH 16
`define RXQ_CNT_WID 5

// adr[31:16] that selects the network
`define NOC_BASE_HI 16'hFFD8

`endif

/* ring_noc_pkg.sv */
`include "ring_noc_params.svh"

package ring_noc_pkg;

  // ========================================================================
  // data types shared across the network
  // ========================================================================

  // one ring slot
  typedef logic [`RING_PACKET_WID-1:0] packet_t;

  // node number as held in the rid and tid fields
  typedef logic [3:0] node_num_t;

  // bus address and data word
  typedef logic [31:0] bus_word_t;

  // register index from adr[4:2]
  typedef logic [2:0] reg_idx_t;

  // receive queue occupancy, needs to reach the full depth
  typedef logic [`RXQ_CNT_WID-1:0] rxq_cnt_t;

  // ========================================================================
  // transmit side of a node
  // ========================================================================

  // idle until the host writes send, then pending until a slot is taken
  typedef enum logic {
    tx_idle,
    tx_pending
  } node_state_t;

endpackage

/* ring_noc_tb.sv */
`timescale 1ns/1ns
`include "ring_noc_params.svh"

module ring_noc_tb;

  // bus cycles allowed for an ack, and status reads allowed for a poll
  localparam int ACK_LIMIT  = 16;
  localparam int POLL_LIMIT = 200;

  // register indices
  localparam int IDX_SEND   = 6;
  localparam int IDX_POP    = 6;
  localparam int IDX_STATUS = 7;

  logic                    clk;
  logic                    rst;
  logic                    cyc;
  logic                    stb;
  logic                    we;
  ring_noc_pkg::bus_word_t adr;
  ring_noc_pkg::bus_word_t dat_w;
  ring_noc_pkg::bus_word_t dat_r;
  logic                    ack;

  int checks;
  int errors;

  ring_noc_top uut (
    .clk   (clk),
    .rst   (rst),
    .cyc   (cyc),
    .stb   (stb),
    .we    (we),
    .adr   (adr),
    .dat_w (dat_w),
    .dat_r (dat_r),
    .ack   (ack)
  );

  // 40 ns period
  initial begin
    clk = 1'b0;
    forever begin
      #20 clk = ~clk;
    end
  end

  // ==========================================================================
  // checks
  // ==========================================================================

  task automatic check_word(input string name, input ring_noc_pkg::bus_word_t expected,
                            input ring_noc_pkg::bus_word_t actual);
    checks++;
    assert (actual === expected) else begin
      $display("FAILED %s expected %h actual %h", name, expected, actual);
      errors++;
    end
  endtask

  task automatic check_true(input logic cond, input string msg);
    checks++;
    assert (cond) else begin
      $display("%s", msg);
      errors++;
    end
  endtask

  // ==========================================================================
  // host bus
  // ==========================================================================

  // base in the top half, node in bits 9:8, register in bits 4:2
  function automatic ring_noc_pkg::bus_word_t node_addr(input int node, input int idx);
    ring_noc_pkg::bus_word_t a;
    a        = '0;
    a[31:16] = `NOC_BASE_HI;
    a[9:8]   = 2'(node - 1);
    a[4:2]   = 3'(idx);
    return a;
  endfunction

  // one select held until ack is seen on a falling edge or the limit runs out
  task automatic bus_cycle(input ring_noc_pkg::bus_word_t a, input logic wr,
                           input ring_noc_pkg::bus_word_t wdata,
                           output ring_noc_pkg::bus_word_t rdata, output logic got_ack);
    int n;
    n       = 0;
    got_ack = 1'b0;
    rdata   = '0;
    @(negedge clk);
    cyc   = 1'b1;
    stb   = 1'b1;
    we    = wr;
    adr   = a;
    dat_w = wdata;
    while (!got_ack && n < ACK_LIMIT) begin
      @(negedge clk);
      if (ack) begin
        got_ack = 1'b1;
        rdata   = dat_r;
      end
      n++;
    end
    cyc = 1'b0;
    stb = 1'b0;
    we  = 1'b0;
  endtask

  task automatic bus_write(input int node, input int idx, input ring_noc_pkg::bus_word_t data);
    ring_noc_pkg::bus_word_t unused;
    logic                    got;
    bus_cycle(node_addr(node, idx), 1'b1, data, unused, got);
    check_true(got, $sformatf("no ack on write to node %0d register %0d", node, idx));
  endtask

  task automatic bus_read(input int node, input int idx, output ring_noc_pkg::bus_word_t data);
    logic got;
    bus_cycle(node_addr(node, idx), 1'b0, '0, data, got);
    check_true(got, $sformatf("no ack on read of node %0d register %0d", node, idx));
  endtask

  // ==========================================================================
  // packets and status
  // ==========================================================================

  // random payload with tid and ack bits left for the node to overwrite
  function automatic ring_noc_pkg::packet_t make_packet(input int dst);
    ring_noc_pkg::packet_t p;
    p[31:0]  = $urandom;
    p[63:32] = $urandom;
    p[95:64] = $urandom;
    p[`RING_RID_HI:`RING_RID_LO] = 4'(dst);
    return p;
  endfunction

  // a receiver holds the packet with the sender stamped and the ack flag clear
  function automatic ring_noc_pkg::packet_t as_received(input ring_noc_pkg::packet_t p,
                                                        input int src);
    ring_noc_pkg::packet_t r;
    r = p;
    r[`RING_TID_HI:`RING_TID_LO] = 4'(src);
    r[`RING_ACK_BIT]             = 1'b0;
    return r;
  endfunction

  task automatic send_packet(input int src, input ring_noc_pkg::packet_t p);
    bus_write(src, 0, p[31:0]);
    bus_write(src, 1, p[63:32]);
    bus_write(src, 2, p[95:64]);
    bus_write(src, IDX_SEND, '0);
  endtask

  task automatic check_head(input int node, input ring_noc_pkg::packet_t p);
    ring_noc_pkg::bus_word_t w;
    for (int k = 0; k < 3; k++) begin
      bus_read(node, k, w);
      check_word($sformatf("node%0d head word%0d", node, k), p[32*k +: 32], w);
    end
  endtask

  task automatic get_count(input int node, output int c);
    ring_noc_pkg::bus_word_t w;
    bus_read(node, IDX_STATUS, w);
    c = int'(w[4:0]);
  endtask

  task automatic check_count(input int node, input int expected);
    int c;
    get_count(node, c);
    check_word($sformatf("node%0d count", node), expected, c);
  endtask

  // poll status until the count hits target
  task automatic wait_count(input int node, input int target);
    int c;
    int n;
    n = 0;
    get_count(node, c);
    while (c != target && n < POLL_LIMIT) begin
      get_count(node, c);
      n++;
    end
    check_true(c == target,
               $sformatf("node %0d count stuck at %0d, waiting for %0d", node, c, target));
  endtask

  // poll status until pending drops as the packet takes a slot
  task automatic wait_idle(input int node);
    ring_noc_pkg::bus_word_t w;
    int n;
    n = 0;
    bus_read(node, IDX_STATUS, w);
    while (w[27] && n < POLL_LIMIT) begin
      bus_read(node, IDX_STATUS, w);
      n++;
    end
    check_true(!w[27], $sformatf("node %0d never sent its pending packet", node));
  endtask

  task automatic drain_queue(input int node);
    ring_noc_pkg::bus_word_t w;
    int c;
    get_count(node, c);
    repeat (c) bus_read(node, IDX_POP, w);
    check_count(node, 0);
  endtask

  task automatic report_test(input string name, input int start_errors);
    if (errors == start_errors) begin
      $display("test %s: ok", name);
    end else begin
      $display("test %s: %0d errors", name, errors - start_errors);
    end
  endtask

  // ==========================================================================
  // sequence
  // ==========================================================================

  initial begin
    ring_noc_pkg::packet_t   pa;
    ring_noc_pkg::packet_t   pb;
    ring_noc_pkg::bus_word_t w;
    logic                    got;
    int                      base [4];
    int                      start;
    void'($urandom(32'he371fd15));
    rst    = 1'b1;
    cyc    = 1'b0;
    stb    = 1'b0;
    we     = 1'b0;
    adr    = '0;
    dat_w  = '0;
    checks = 0;
    errors = 0;
    repeat (10) @(negedge clk);
    rst = 1'b0;

    // reset state, unused register, and an address outside the network
    start = errors;
    for (int n = 1; n <= 4; n++) begin
      bus_read(n, IDX_STATUS, w);
      check_word($sformatf("node%0d status", n), {4'(n), 28'd0}, w);
    end
    bus_read(1, 3, w);
    check_word("node1 reg3", '0, w);
    bus_cycle(32'h1234_001c, 1'b0, '0, w, got);
    check_true(!got, "access outside the base address was acknowledged");
    report_test("reset state", start);

    // node 1 to node 3
    start = errors;
    pa = make_packet(3);
    send_packet(1, pa);
    wait_count(3, 1);
    check_head(3, as_received(pa, 1));
    wait_idle(1);
    check_count(2, 0);
    check_count(4, 0);
    report_test("unicast", start);

    // broadcast from node 2 must not pile up on the way round
    start = errors;
    for (int n = 1; n <= 4; n++) begin
      get_count(n, base[n-1]);
    end
    pb = make_packet(`RING_GBL);
    send_packet(2, pb);
    wait_count(1, base[0] + 1);
    wait_count(3, base[2] + 1);
    wait_count(4, base[3] + 1);
    wait_idle(2);
    repeat (40) @(negedge clk);
    for (int n = 1; n <= 4; n++) begin
      check_count(n, (n == 2) ? base[n-1] : base[n-1] + 1);
    end
    check_head(4, as_received(pb, 2));
    for (int n = 1; n <= 4; n++) begin
      drain_queue(n);
    end
    report_test("broadcast", start);

    // oldest comes out first and a pop on empty is ignored
    start = errors;
    pa = make_packet(4);
    pb = make_packet(4);
    send_packet(1, pa);
    wait_idle(1);
    wait_count(4, 1);
    send_packet(1, pb);
    wait_idle(1);
    wait_count(4, 2);
    check_head(4, as_received(pa, 1));
    bus_read(4, IDX_POP, w);
    check_count(4, 1);
    check_head(4, as_received(pb, 1));
    bus_read(4, IDX_POP, w);
    check_count(4, 0);
    bus_read(4, IDX_POP, w);
    check_count(4, 0);
    report_test("pop and order", start);

    // one packet more than node 3 holds keeps circulating until a pop
    start = errors;
    for (int k = 0; k <= `RXQ_DEPTH; k++) begin
      wait_idle(1);
      pa = make_packet(3);
      send_packet(1, pa);
    end
    wait_idle(1);
    wait_count(3, `RXQ_DEPTH);
    repeat (20) @(negedge clk);
    check_count(3, `RXQ_DEPTH);
    bus_read(3, IDX_POP, w);
    wait_count(3, `RXQ_DEPTH);
    // the retried packet is now the newest entry
    repeat (`RXQ_DEPTH - 1) bus_read(3, IDX_POP, w);
    check_count(3, 1);
    check_head(3, as_received(pa, 1));
    report_test("full queue and retry", start);

    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

/* ring_noc_top.sv */
`timescale 1ns/1ns
`include "ring_noc_params.svh"

// four node ring with a single host bus in front
module ring_noc_top (
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    cyc,
  input  logic                    stb,
  input  logic                    we,
  input  ring_noc_pkg::bus_word_t adr,
  input  ring_noc_pkg::bus_word_t dat_w,
  output ring_noc_pkg::bus_word_t dat_r,
  output logic                    ack
);

  // one slave bus per node
  noc_bus_if node_bus [`RING_NODES] ();

  // ring[k] is the registered output of node k+1
  ring_noc_pkg::packet_t ring [`RING_NODES];

  // ========================================================================
  // host side
  // ========================================================================

  bus_decode u_dec (
    .cyc   (cyc),
    .stb   (stb),
    .we    (we),
    .adr   (adr),
    .dat_w (dat_w),
    .dat_r (dat_r),
    .ack   (ack),
    .nodes (node_bus)
  );

  // ========================================================================
  // ring
  // ========================================================================

  // node 1 takes its input from the last node, closing the loop
  for (genvar g = 0; g < `RING_NODES; g++) begin : g_node
    ring_node #(
      .NODE_ID (g + 1)
    ) u_node (
      .clk      (clk),
      .rst      (rst),
      .bus      (node_bus[g]),
      .ring_in  (ring[(g + `RING_NODES - 1) % `RING_NODES]),
      .ring_out (ring[g])
    );
  end

endmodule

/* ring_node.sv */
`timescale 1ns/1ns
`include "ring_noc_params.svh"

// one ring station
// forwards, accepts, acknowledges and inserts packets on the ring
// and exposes transmit words, the receive head and status to the host
module ring_node #(
  parameter int NODE_ID = 1
) (
  input  logic                  clk,
  input  logic                  rst,
  noc_bus_if.node               bus,
  input  ring_noc_pkg::packet_t ring_in,
  output ring_noc_pkg::packet_t ring_out
);

  // register indices
  localparam ring_noc_pkg::reg_idx_t REG_W0     = 3'd0;
  localparam ring_noc_pkg::reg_idx_t REG_W1     = 3'd1;
  localparam ring_noc_pkg::reg_idx_t REG_W2     = 3'd2;
  localparam ring_noc_pkg::reg_idx_t REG_SEND   = 3'd6;
  localparam ring_noc_pkg::reg_idx_t REG_STATUS = 3'd7;

  localparam ring_noc_pkg::node_num_t MY_NUM  = ring_noc_pkg::node_num_t'(NODE_ID);
  localparam ring_noc_pkg::node_num_t GBL_NUM = ring_noc_pkg::node_num_t'(`RING_GBL);

  ring_noc_pkg::node_num_t   in_rid;
  ring_noc_pkg::node_num_t   in_tid;
  logic                      in_ack;
  ring_noc_pkg::packet_t     ring_nxt;
  logic                      rx_push;
  logic                      tx_take;
  ring_noc_pkg::node_state_t tx_state;
  ring_noc_pkg::packet_t     tx_pkt;
  ring_noc_pkg::packet_t     q_head;
  ring_noc_pkg::rxq_cnt_t    q_count;
  logic                      q_full;
  logic                      q_pop;
  logic                      cs;
  ring_noc_pkg::reg_idx_t    idx;
  logic                      rd_ack;
  ring_noc_pkg::bus_word_t   rd_word;
  ring_noc_pkg::bus_word_t   rd_q;

  rx_queue #(
    .DEPTH (`RXQ_DEPTH)
  ) u_rxq (
    .clk   (clk),
    .rst   (rst),
    .push  (rx_push),
    .din   (ring_in),
    .pop   (q_pop),
    .head  (q_head),
    .count (q_count),
    .full  (q_full)
  );

  // ========================================================================
  // ring forwarding
  // ========================================================================

  assign in_rid = ring_in[`RING_RID_HI:`RING_RID_LO];
  assign in_tid = ring_in[`RING_TID_HI:`RING_TID_LO];
  assign in_ack = ring_in[`RING_ACK_BIT];

  always_comb begin
    ring_nxt = ring_in;
    rx_push  = 1'b0;
    tx_take  = 1'b0;
    if (in_tid == MY_NUM) begin
      // own packet came back
      // unicast goes round again, broadcast has visited everyone
      if (in_rid == GBL_NUM) begin
        ring_nxt = '0;
      end
    end else if (in_rid == MY_NUM && in_ack) begin
      // acknowledge for us frees the slot, reuse it if we have something
      if (tx_state == ring_noc_pkg::tx_pending) begin
        ring_nxt = tx_pkt;
        tx_take  = 1'b1;
      end else begin
        ring_nxt = '0;
      end
    end else if (in_rid == MY_NUM) begin
      // queue it and turn the slot into an ack for the sender
      // when full leave it alone so the sender retries
      if (!q_full) begin
        rx_push                                 = 1'b1;
        ring_nxt[`RING_RID_HI:`RING_RID_LO]     = in_tid;
        ring_nxt[`RING_TID_HI:`RING_TID_LO]     = in_rid;
        ring_nxt[`RING_ACK_BIT]                 = 1'b1;
      end
    end else if (in_rid == GBL_NUM) begin
      // take a copy if there is room, always pass it on
      rx_push = !q_full;
    end else if (in_rid == '0 && tx_state == ring_noc_pkg::tx_pending) begin
      // empty slot
      ring_nxt = tx_pkt;
      tx_take  = 1'b1;
    end
  end

  // ========================================================================
  // bus slave
  // ========================================================================

  assign cs  = bus.cyc && bus.stb && (bus.adr[31:16] == `NOC_BASE_HI);
  assign idx = bus.adr[4:2];

  // writes ack at once, reads one cycle after select
  assign bus.ack   = cs && (bus.we || rd_ack);
  assign bus.dat_r = (cs && !bus.we && rd_ack) ? rd_q : '0;

  // pop only on the first cycle of the read
  assign q_pop = cs && !bus.we && !rd_ack && (idx == 3'd6);

  always_comb begin
    case (idx)
      REG_W0:     rd_word = q_head[31:0];
      REG_W1:     rd_word = q_head[63:32];
      REG_W2:     rd_word = q_head[95:64];
      REG_STATUS: rd_word = {MY_NUM, (tx_state == ring_noc_pkg::tx_pending), 22'd0, q_count};
      default:    rd_word = '0;
    endcase
  end

  // control state
  always_ff @(posedge clk) begin
    if (rst) begin
      ring_out <= '0;
      tx_state <= ring_noc_pkg::tx_idle;
      rd_ack   <= 1'b0;
    end else begin
      ring_out <= ring_nxt;
      rd_ack   <= cs && !bus.we;
      if (tx_take) begin
        tx_state <= ring_noc_pkg::tx_idle;
      end
      // a new send wins over a slot taken in the same cycle
      if (cs && bus.we && idx == REG_SEND) begin
        tx_state <= ring_noc_pkg::tx_pending;
      end
    end
  end

  // transmit packet and read capture
  always_ff @(posedge clk) begin
    if (cs && bus.we) begin
      case (idx)
        REG_W0: tx_pkt[31:0]  <= bus.dat_w;
        REG_W1: tx_pkt[63:32] <= bus.dat_w;
        REG_W2: begin
          tx_pkt[95:64]                     <= bus.dat_w;
          // stamp sender and make sure it is not taken for an ack
          tx_pkt[`RING_TID_HI:`RING_TID_LO] <= MY_NUM;
          tx_pkt[`RING_ACK_BIT]             <= 1'b0;
        end
        default: ;
      endcase
    end
    // hold the value seen at select so a pop does not change it
    if (cs && !bus.we && !rd_ack) begin
      rd_q <= rd_word;
    end
  end

endmodule

/* run_sim.sh */
#!/bin/sh
# build the ring testbench with verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  -f ring_noc.f --top-module ring_noc_tb -o ring_noc_sim
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

out=$(./obj_dir/ring_noc_sim)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if echo "$out" | grep -q "TESTS PASSED"; then
  exit 0
fi
exit 1

/* rx_queue.sv */
`timescale 1ns/1ns
`include "ring_noc_params.svh"

// receive queue built as a shift-in delay line
// newest entry sits at stage 0, the oldest at stage count-1
module rx_queue #(
  parameter int DEPTH = `RXQ_DEPTH
) (
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     push,
  input  ring_noc_pkg::packet_t    din,
  input  logic                     pop,
  output ring_noc_pkg::packet_t    head,
  output ring_noc_pkg::rxq_cnt_t   count,
  output logic                     full
);

  localparam int TAP_WID = $clog2(DEPTH);

  ring_noc_pkg::packet_t stages [DEPTH];
  logic [TAP_WID-1:0]    tap;
  logic                  push_ok;
  logic                  pop_ok;

  assign full = (count == ring_noc_pkg::rxq_cnt_t'(DEPTH));

  // a full queue drops the push, an empty one ignores the pop
  assign push_ok = push && !full;
  assign pop_ok  = pop && (count != '0);

  // oldest entry
  assign tap  = TAP_WID'(count - 1'b1);
  assign head = (count == '0) ? '0 : stages[tap];

  // ========================================================================
  // delay line
  // ========================================================================

  always_ff @(posedge clk) begin
    if (push_ok) begin
      stages[0] <= din;
      for (int i = 1; i < DEPTH; i++) begin
        stages[i] <= stages[i-1];
      end
    end
  end

  // occupancy
  // push with pop shifts the line by one and drops the oldest off the tap
  always_ff @(posedge clk) begin
    if (rst) begin
      count <= '0;
    end else if (push_ok && !pop_ok) begin
      count <= count + 1'b1;
    end else if (pop_ok && !push_ok) begin
      count <= count - 1'b1;
    end
  end

endmodule
